//--- list.f
rtl/ntt_pkg.sv
rtl/ntt_ctrl_fsm.sv
rtl/ntt_addr_gen.sv
rtl/ntt_butterfly.sv
rtl/ntt_mem.sv
rtl/ntt_out_credit.sv
rtl/ntt_top.sv
verif/ntt_tb_props.sv
verif/ntt_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module ntt_tb -f list.f -Mdir obj_dir
./obj_dir/Vntt_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- verif/ntt_tb.sv
// ntt engine directed testbench
// drives loads, runs and credit-controlled output through the top level
// and checks every beat against the direct O(N^2) transform sum

`timescale 1ns/1ps

module ntt_tb import ntt_pkg::*; ();

    localparam int          LOG_N        = 4;
    localparam int          N            = 1 << LOG_N;
    localparam int unsigned Q            = 7681;
    localparam longint      QL           = Q;
    localparam int          BFLY_LATENCY = 3;
    localparam int          OUT_CREDITS  = 4;
    localparam int          RESET_CYCLES = 8;
    localparam int          WAIT_LIMIT   = 2000;
    localparam int          STALL_CYCLES = 200;   // long enough to outlast the transform
    localparam int          RANDOM_SETS  = 20;

    logic      clk;
    logic      reset;
    ntt_cmd_e  cmd;
    in_beat_t  din;
    logic      credit_return;
    out_beat_t dout;
    logic      busy;
    logic      done;

    integer            seed;
    longint            w_root;
    int                coef [N];
    logic [DATA_W-1:0] expected [N];

    ntt_top #(.LOG_N(LOG_N), .Q(Q), .BFLY_LATENCY(BFLY_LATENCY), .OUT_CREDITS(OUT_CREDITS)) uut (
        .clk, .reset, .cmd, .din, .credit_return, .dout, .busy, .done
    );

    always #5 clk = ~clk;

    function automatic longint mod_pow(input longint base, input int e);
        longint r;
        r = 1;
        for (int i = 0; i < e; i++) begin
            r = (r * base) % QL;
        end
        return r;
    endfunction

    // smallest w of order exactly N
    function automatic longint find_root();
        for (longint w = 2; w < QL; w++) begin
            if (mod_pow(w, N) == 1 && mod_pow(w, N / 2) != 1) return w;
        end
        return 0;
    endfunction

    // X[k] = sum_j a[j] * w^(j*k) mod Q
    function automatic void compute_expected();
        longint acc;
        for (int k = 0; k < N; k++) begin
            acc = 0;
            for (int j = 0; j < N; j++) begin
                acc = (acc + longint'(coef[j]) * mod_pow(w_root, (j * k) % N)) % QL;
            end
            expected[k] = DATA_W'(acc);
        end
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp)
            report_failure($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_index(input string name, input logic [ADDR_W-1:0] exp,
                               input logic [ADDR_W-1:0] act);
        if (act !== exp)
            report_failure($sformatf("error %s: expected index %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_failure($sformatf("error %s: expected %b, actual %b", name, exp, act));
    endtask

    // one-cycle command, then wait for busy to rise
    task automatic issue_cmd(input string name, input ntt_cmd_e c);
        int cycles;
        cycles = 0;
        @(posedge clk);
        cmd <= c;
        @(posedge clk);
        cmd <= CMD_NONE;
        @(negedge clk);
        while (!busy) begin
            cycles++;
            if (cycles > WAIT_LIMIT) report_failure({"timeout in ", name, ": busy never rose"});
            @(negedge clk);
        end
    endtask

    task automatic wait_idle(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy) begin
            cycles++;
            if (cycles > WAIT_LIMIT) report_failure({"timeout in ", name, ": busy never fell"});
            @(negedge clk);
        end
    endtask

    task automatic load_twiddles(input string name);
        issue_cmd(name, CMD_LOAD_TW);
        for (int i = 0; i < N / 2; i++) begin
            @(posedge clk);
            din <= '{valid: 1'b1, data: DATA_W'(mod_pow(w_root, i))};
        end
        @(posedge clk);
        din <= '{valid: 1'b0, data: '0};
        wait_idle(name);
    endtask

    task automatic load_coeffs(input string name);
        issue_cmd(name, CMD_LOAD_DATA);
        for (int i = 0; i < N; i++) begin
            @(posedge clk);
            din <= '{valid: 1'b1, data: DATA_W'(coef[i])};
        end
        @(posedge clk);
        din <= '{valid: 1'b0, data: '0};
        wait_idle(name);
    endtask

    task automatic run_transform(input string name);
        issue_cmd(name, CMD_RUN);
    endtask

    // mode 0 returns credits at once, 1 withholds them then frees one at a time,
    // 2 returns at once and throws commands at the busy engine
    task automatic collect_output(input string name, input int mode);
        int got;
        int owed;
        int cycles;
        int stall;
        bit pending;
        bit seen_done;
        got = 0;
        owed = 0;
        cycles = 0;
        stall = 0;
        pending = 0;
        seen_done = 0;
        while (!(seen_done && owed == 0)) begin
            @(negedge clk);
            if (dout.valid) begin
                if (got >= N) report_failure({name, ": beat arrived after the last index"});
                check_index(name, ADDR_W'(got), dout.index);
                check_flag(name, logic'(got == N - 1), dout.last);
                check_word(name, expected[got], dout.data);
                got++;
                owed++;
                pending = 0;
            end
            if (done) begin
                if (got != N) report_failure({name, ": done pulsed before the last beat"});
                check_flag(name, 1'b0, busy);
                seen_done = 1;
            end
            if (mode == 1 && stall < STALL_CYCLES) begin
                stall++;
                if (got > OUT_CREDITS) report_failure({name, ": more beats than credits"});
                if (stall == STALL_CYCLES && got != OUT_CREDITS)
                    report_failure({name, ": stream did not use all initial credits"});
            end
            cycles++;
            if (cycles > WAIT_LIMIT + STALL_CYCLES)
                report_failure({"timeout in ", name, ": output stream did not finish"});
            @(posedge clk);
            credit_return <= 1'b0;
            if (owed > 0 && (mode != 1 || (stall >= STALL_CYCLES && (!pending || got == N)))) begin
                credit_return <= 1'b1;
                owed--;
                pending = 1;
            end
            if (mode == 2) begin
                cmd <= (got == 2) ? CMD_RUN : (got == 3) ? CMD_LOAD_DATA : CMD_NONE;
                din <= '{valid: (got == 3), data: DATA_W'(16'h1234)};
            end
        end
        @(posedge clk);
        credit_return <= 1'b0;
    endtask

    task automatic fill_random();
        for (int i = 0; i < N; i++) begin
            coef[i] = int'($unsigned($random(seed)) % Q);
        end
        compute_expected();
    endtask

    task automatic reset_idle_test();
        repeat (20) begin
            @(negedge clk);
            check_flag("reset_idle busy", 1'b0, busy);
            check_flag("reset_idle done", 1'b0, done);
            check_flag("reset_idle dout.valid", 1'b0, dout.valid);
        end
    endtask

    task automatic impulse_test();
        for (int i = 0; i < N; i++) begin
            coef[i] = (i == 0) ? 1 : 0;
            expected[i] = DATA_W'(1);   // flat spectrum
        end
        load_twiddles("impulse");
        load_coeffs("impulse");
        run_transform("impulse");
        collect_output("impulse", 0);
    endtask

    task automatic random_test();
        for (int s = 0; s < RANDOM_SETS; s++) begin
            fill_random();
            load_coeffs($sformatf("random_%0d", s));
            run_transform($sformatf("random_%0d", s));
            collect_output($sformatf("random_%0d", s), 0);
        end
    endtask

    task automatic backpressure_test();
        fill_random();
        load_coeffs("backpressure");
        run_transform("backpressure");
        collect_output("backpressure", 1);
    endtask

    task automatic busy_cmd_test();
        fill_random();
        load_coeffs("busy_cmd");
        run_transform("busy_cmd");
        @(posedge clk);
        cmd <= CMD_LOAD_TW;                 // lands mid transform
        din <= '{valid: 1'b1, data: DATA_W'(16'h0bad)};
        @(posedge clk);
        cmd <= CMD_NONE;
        din <= '{valid: 1'b0, data: '0};
        collect_output("busy_cmd", 2);
        load_coeffs("busy_cmd_rerun");
        run_transform("busy_cmd_rerun");
        collect_output("busy_cmd_rerun", 0);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        cmd = CMD_NONE;
        din = '0;
        credit_return = 1'b0;
        seed = 32'ha18c_8c2b;
        w_root = find_root();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        if (w_root == 0) report_failure("no root of unity of order N exists for this modulus");
        reset_idle_test();
        impulse_test();
        random_test();
        backpressure_test();
        busy_cmd_test();
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- verif/ntt_tb_props.sv
// protocol properties for the ntt engine top level
// bound onto ntt_top, checks busy/done/output framing

`timescale 1ns/1ps

module ntt_tb_props import ntt_pkg::*; (
    input logic      clk,
    input logic      reset,
    input out_beat_t dout,
    input logic      busy,
    input logic      done
);

    // beats only while an operation is running
    a_valid_busy: assert property (@(posedge clk) disable iff (reset) dout.valid |-> busy)
        else $error("output beat seen while not busy");

    // done is a single pulse on the cycle busy drops
    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |-> (!busy && $past(busy)) ##1 !done)
        else $error("done is not a one cycle pulse aligned with busy falling");

    a_reset_quiet: assert property (@(posedge clk) reset |-> !busy && !done && !dout.valid)
        else $error("outputs active during reset");

endmodule

bind ntt_top ntt_tb_props u_props (.clk, .reset, .dout, .busy, .done);

//--- rtl/ntt_top.sv
// iterative radix-2 ntt engine, single butterfly
// loads twiddles and bit-reversed coefficients, runs the forward
// transform in place and streams results out under credit control

`timescale 1ns/1ps

module ntt_top import ntt_pkg::*; #(
    parameter int          LOG_N        = 4,
    parameter int unsigned Q            = 7681,
    parameter int          BFLY_LATENCY = 3,
    parameter int          OUT_CREDITS  = 4
) (
    input  logic      clk,
    input  logic      reset,
    input  ntt_cmd_e  cmd,
    input  in_beat_t  din,
    input  logic      credit_return,
    output out_beat_t dout,
    output logic      busy,
    output logic      done
);

    ntt_state_e        state;
    load_wr_t          load_wr;
    bfly_req_t         bfly_req;
    bfly_res_t         bfly_res;
    logic              run_start;
    logic              run_done;
    logic              out_start;
    logic              out_done;
    logic              op_valid;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] op_w;
    logic [ADDR_W-1:0] op_addr_a;
    logic [ADDR_W-1:0] op_addr_b;
    logic              out_rd_valid;
    logic [ADDR_W-1:0] out_rd_addr;
    logic [DATA_W-1:0] out_rd_data;

    ntt_ctrl_fsm #(.LOG_N(LOG_N)) u_ctrl (
        .clk, .reset, .cmd, .din, .run_done, .out_done,
        .state, .load_wr, .run_start, .out_start, .busy, .done
    );

    ntt_addr_gen #(.LOG_N(LOG_N), .BFLY_LATENCY(BFLY_LATENCY)) u_addr (
        .clk, .reset, .run_start, .bfly_req, .run_done
    );

    ntt_mem #(.LOG_N(LOG_N)) u_mem (
        .clk, .reset, .state, .load_wr, .bfly_req, .bfly_res,
        .out_rd_valid, .out_rd_addr,
        .op_valid, .op_a, .op_b, .op_w, .op_addr_a, .op_addr_b, .out_rd_data
    );

    ntt_butterfly #(.Q(Q), .BFLY_LATENCY(BFLY_LATENCY)) u_bfly (
        .clk, .reset, .op_valid, .op_a, .op_b, .op_w, .op_addr_a, .op_addr_b, .bfly_res
    );

    ntt_out_credit #(.LOG_N(LOG_N), .OUT_CREDITS(OUT_CREDITS)) u_out (
        .clk, .reset, .out_start, .credit_return, .out_rd_data,
        .out_rd_valid, .out_rd_addr, .dout, .out_done
    );

endmodule

//--- rtl/ntt_out_credit.sv
// credit-based output streamer
// reads the N results in index order, one read per available credit,
// and turns each returned word into an indexed beat, last on N-1

`timescale 1ns/1ps

module ntt_out_credit import ntt_pkg::*; #(
    parameter int LOG_N       = 4,
    parameter int OUT_CREDITS = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              out_start,
    input  logic              credit_return,
    input  logic [DATA_W-1:0] out_rd_data,
    output logic              out_rd_valid,
    output logic [ADDR_W-1:0] out_rd_addr,
    output out_beat_t         dout,
    output logic              out_done
);

    localparam int N      = 1 << LOG_N;
    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    logic              active;
    logic [ADDR_W-1:0] rd_idx;
    logic [CRED_W-1:0] credits;
    logic              beat_valid;
    logic              beat_last;
    logic [ADDR_W-1:0] beat_index;

    assign out_rd_valid = active && (credits != '0);  // stall at zero credit
    assign out_rd_addr  = rd_idx;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active     <= 1'b0;
            rd_idx     <= '0;
            credits    <= CRED_W'(OUT_CREDITS);
            beat_valid <= 1'b0;
            out_done   <= 1'b0;
        end else begin
            if (out_start) begin
                active <= 1'b1;
                rd_idx <= '0;
            end else if (out_rd_valid) begin
                rd_idx <= rd_idx + 1'b1;
                if (rd_idx == ADDR_W'(N - 1)) active <= 1'b0;
            end
            credits    <= credits - CRED_W'(out_rd_valid) + CRED_W'(credit_return);
            beat_valid <= out_rd_valid;
            out_done   <= beat_valid && beat_last;
        end
    end

    // index and last travel one cycle behind the read, like the data
    always_ff @(posedge clk) begin
        beat_index <= rd_idx;
        beat_last  <= (rd_idx == ADDR_W'(N - 1));
    end

    assign dout = '{valid: beat_valid, last: beat_last, index: beat_index, data: out_rd_data};

endmodule

//--- rtl/ntt_mem.sv
// coefficient store and twiddle table
// N coefficient words and N/2 twiddles, registered reads.
// the port use follows the controller state: load writes while loading,
// butterfly reads and two-word write-back during the transform, and
// streamer reads during output

`timescale 1ns/1ps

module ntt_mem import ntt_pkg::*; #(
    parameter int LOG_N = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  ntt_state_e        state,
    input  load_wr_t          load_wr,
    input  bfly_req_t         bfly_req,
    input  bfly_res_t         bfly_res,
    input  logic              out_rd_valid,
    input  logic [ADDR_W-1:0] out_rd_addr,
    output logic              op_valid,
    output logic [DATA_W-1:0] op_a,
    output logic [DATA_W-1:0] op_b,
    output logic [DATA_W-1:0] op_w,
    output logic [ADDR_W-1:0] op_addr_a,
    output logic [ADDR_W-1:0] op_addr_b,
    output logic [DATA_W-1:0] out_rd_data
);

    localparam int N    = 1 << LOG_N;
    localparam int HALF = N / 2;

    logic [DATA_W-1:0] coef_mem [N];
    logic [DATA_W-1:0] tw_mem   [HALF];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) op_valid <= 1'b0;
        else       op_valid <= (state == ST_TRANSFORM) && bfly_req.valid;
    end

    always_ff @(posedge clk) begin
        case (state)
            ST_LOAD_TW, ST_LOAD_DATA: begin
                if (load_wr.valid && load_wr.tw_sel)
                    tw_mem[load_wr.addr[LOG_N-2:0]] <= load_wr.data;
                if (load_wr.valid && !load_wr.tw_sel)
                    coef_mem[load_wr.addr[LOG_N-1:0]] <= load_wr.data;
            end
            ST_TRANSFORM: begin
                op_a      <= coef_mem[bfly_req.addr_a[LOG_N-1:0]];
                op_b      <= coef_mem[bfly_req.addr_b[LOG_N-1:0]];
                op_w      <= tw_mem[bfly_req.tw_addr[LOG_N-2:0]];
                op_addr_a <= bfly_req.addr_a;  // carried with the operands
                op_addr_b <= bfly_req.addr_b;
                // in-place write-back of both butterfly outputs
                if (bfly_res.valid) begin
                    coef_mem[bfly_res.addr_a[LOG_N-1:0]] <= bfly_res.res_a;
                    coef_mem[bfly_res.addr_b[LOG_N-1:0]] <= bfly_res.res_b;
                end
            end
            ST_OUTPUT: begin
                if (out_rd_valid) out_rd_data <= coef_mem[out_rd_addr[LOG_N-1:0]];
            end
            default: ;
        endcase
    end

endmodule

//--- rtl/ntt_butterfly.sv
// pipelined cooley-tukey butterfly
// res_a = (A + W*B) mod Q, res_b = (A - W*B) mod Q
// stage 1 forms W*B mod Q, stage 2 the modular sum and difference,
// remaining stages only delay so the total latency is BFLY_LATENCY

`timescale 1ns/1ps

module ntt_butterfly import ntt_pkg::*; #(
    parameter int unsigned Q   = 7681,
    parameter int BFLY_LATENCY = 3     // at least 2
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              op_valid,
    input  logic [DATA_W-1:0] op_a,
    input  logic [DATA_W-1:0] op_b,
    input  logic [DATA_W-1:0] op_w,
    input  logic [ADDR_W-1:0] op_addr_a,
    input  logic [ADDR_W-1:0] op_addr_b,
    output bfly_res_t         bfly_res
);

    localparam logic [DATA_W:0] Q_W = (DATA_W + 1)'(Q);

    logic [2*DATA_W-1:0] prod_full;
    logic                s1_valid;
    logic [DATA_W-1:0]   s1_a;
    logic [DATA_W-1:0]   s1_wb;
    logic [ADDR_W-1:0]   s1_addr_a;
    logic [ADDR_W-1:0]   s1_addr_b;
    logic [DATA_W:0]     sum;
    logic [DATA_W:0]     diff;
    bfly_res_t           pipe [BFLY_LATENCY-1];

    assign prod_full = op_w * op_b;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) s1_valid <= 1'b0;
        else       s1_valid <= op_valid;
    end

    always_ff @(posedge clk) begin
        s1_a      <= op_a;
        s1_wb     <= DATA_W'(prod_full % Q);  // plain reduction, no barrett
        s1_addr_a <= op_addr_a;
        s1_addr_b <= op_addr_b;
    end

    assign sum  = {1'b0, s1_a} + {1'b0, s1_wb};
    assign diff = {1'b0, s1_a} + Q_W - {1'b0, s1_wb};  // never negative

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < BFLY_LATENCY - 1; k++) begin
                pipe[k] <= '0;
            end
        end else begin
            pipe[0].valid  <= s1_valid;
            pipe[0].addr_a <= s1_addr_a;
            pipe[0].addr_b <= s1_addr_b;
            pipe[0].res_a  <= DATA_W'((sum >= Q_W) ? sum - Q_W : sum);
            pipe[0].res_b  <= DATA_W'((diff >= Q_W) ? diff - Q_W : diff);
            for (int k = 1; k < BFLY_LATENCY - 1; k++) begin
                pipe[k] <= pipe[k-1];
            end
        end
    end

    assign bfly_res = pipe[BFLY_LATENCY-2];

endmodule

//--- rtl/ntt_addr_gen.sv
// butterfly address generator
// walks LOG_N stages of N/2 butterflies, one issue per cycle, deriving
// both operand addresses and the twiddle index from the half span.
// a drain gap after each stage lets the last write-back land before the
// next stage reads the same words

`timescale 1ns/1ps

module ntt_addr_gen import ntt_pkg::*; #(
    parameter int LOG_N        = 4,
    parameter int BFLY_LATENCY = 3
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      run_start,
    output bfly_req_t bfly_req,
    output logic      run_done
);

    localparam int HALF  = 1 << (LOG_N - 1);
    localparam int DRN_W = $clog2(BFLY_LATENCY + 1);

    logic              running;
    logic              draining;
    logic [3:0]        stage;
    logic [ADDR_W-1:0] bfly_idx;
    logic [DRN_W-1:0]  drain_cnt;

    logic [ADDR_W-1:0] span;
    logic [ADDR_W-1:0] pos;
    logic [ADDR_W-1:0] grp;
    logic [ADDR_W-1:0] addr_a;
    logic [3:0]        tw_shift;

    always_comb begin
        span     = ADDR_W'(1) << stage;         // h = 2^s
        pos      = bfly_idx & (span - 1'b1);    // j mod h
        grp      = bfly_idx >> stage;           // j div h
        addr_a   = (grp << (stage + 1'b1)) | pos;
        tw_shift = 4'(LOG_N - 1) - stage;

        bfly_req.valid   = running && !draining;
        bfly_req.addr_a  = addr_a;
        bfly_req.addr_b  = addr_a + span;
        bfly_req.tw_addr = pos << tw_shift;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running   <= 1'b0;
            draining  <= 1'b0;
            stage     <= '0;
            bfly_idx  <= '0;
            drain_cnt <= '0;
            run_done  <= 1'b0;
        end else begin
            run_done <= 1'b0;
            if (run_start) begin
                running  <= 1'b1;
                draining <= 1'b0;
                stage    <= '0;
                bfly_idx <= '0;
            end else if (running && !draining) begin
                if (bfly_idx == ADDR_W'(HALF - 1)) begin
                    bfly_idx  <= '0;
                    draining  <= 1'b1;
                    drain_cnt <= '0;
                end else begin
                    bfly_idx <= bfly_idx + 1'b1;
                end
            end else if (running) begin
                // 1 + BFLY_LATENCY idle cycles between stages
                if (drain_cnt == DRN_W'(BFLY_LATENCY)) begin
                    draining <= 1'b0;
                    if (stage == 4'(LOG_N - 1)) begin
                        running  <= 1'b0;
                        run_done <= 1'b1;
                    end else begin
                        stage <= stage + 1'b1;
                    end
                end else begin
                    drain_cnt <= drain_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/ntt_ctrl_fsm.sv
// ntt top-level controller
// accepts commands in idle, counts load beats and steers them into the
// twiddle table or, bit reversed, into the coefficient store, then
// sequences transform and output and reports busy/done

`timescale 1ns/1ps

module ntt_ctrl_fsm import ntt_pkg::*; #(
    parameter int LOG_N = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  ntt_cmd_e   cmd,
    input  in_beat_t   din,
    input  logic       run_done,
    input  logic       out_done,
    output ntt_state_e state,
    output load_wr_t   load_wr,
    output logic       run_start,
    output logic       out_start,
    output logic       busy,
    output logic       done
);

    localparam int N = 1 << LOG_N;

    logic [ADDR_W-1:0] beat_cnt;
    logic [ADDR_W-1:0] beat_rev;
    logic              table_end;

    // beat index mirrored over LOG_N bits
    always_comb begin
        beat_rev = '0;
        for (int i = 0; i < LOG_N; i++) begin
            beat_rev[i] = beat_cnt[LOG_N-1-i];
        end
    end

    // twiddle table holds N/2 words, coefficient store N
    assign table_end = (state == ST_LOAD_TW) ? (beat_cnt == ADDR_W'(N/2 - 1))
                                             : (beat_cnt == ADDR_W'(N - 1));

    always_comb begin
        load_wr.valid  = din.valid && (state == ST_LOAD_TW || state == ST_LOAD_DATA);
        load_wr.tw_sel = (state == ST_LOAD_TW);
        load_wr.addr   = (state == ST_LOAD_TW) ? beat_cnt : beat_rev;
        load_wr.data   = din.data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= ST_IDLE;
            beat_cnt  <= '0;
            run_start <= 1'b0;
            out_start <= 1'b0;
        end else begin
            run_start <= 1'b0;
            out_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    beat_cnt <= '0;
                    case (cmd)
                        CMD_LOAD_TW:   state <= ST_LOAD_TW;
                        CMD_LOAD_DATA: state <= ST_LOAD_DATA;
                        CMD_RUN: begin
                            state     <= ST_TRANSFORM;
                            run_start <= 1'b1;
                        end
                        default: ;
                    endcase
                end
                ST_LOAD_TW, ST_LOAD_DATA: begin
                    if (load_wr.valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (table_end) state <= ST_IDLE;  // last word goes in this edge
                    end
                end
                ST_TRANSFORM: begin
                    if (run_done) begin
                        state     <= ST_OUTPUT;
                        out_start <= 1'b1;
                    end
                end
                ST_OUTPUT: if (out_done) state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // done and the falling edge of busy land in the same cycle
    assign done = out_done && (state == ST_OUTPUT);
    assign busy = (state != ST_IDLE) && !done;

endmodule

//--- rtl/ntt_pkg.sv
// ntt engine shared definitions
// widths, command and state encodings, and the packed beats and
// requests that move between the controller, memory, butterfly and
// output streamer

package ntt_pkg;

    parameter int DATA_W = 16;      // must hold any residue below Q
    parameter int ADDR_W = 8;       // covers N up to 256

    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_LOAD_TW,
        CMD_LOAD_DATA,
        CMD_RUN
    } ntt_cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD_TW,
        ST_LOAD_DATA,
        ST_TRANSFORM,
        ST_OUTPUT
    } ntt_state_e;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } in_beat_t;

    typedef struct packed {
        logic              valid;
        logic              tw_sel;  // 1 = twiddle table, 0 = coefficient
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } load_wr_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr_a;
        logic [ADDR_W-1:0] addr_b;
        logic [ADDR_W-1:0] tw_addr;
    } bfly_req_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr_a;
        logic [ADDR_W-1:0] addr_b;
        logic [DATA_W-1:0] res_a;
        logic [DATA_W-1:0] res_b;
    } bfly_res_t;

    typedef struct packed {
        logic              valid;
        logic              last;
        logic [ADDR_W-1:0] index;
        logic [DATA_W-1:0] data;
    } out_beat_t;

endpackage
